//--- source/vmul_defines.svh
`ifndef VMUL_DEFINES_SVH
`define VMUL_DEFINES_SVH

// Operand word seen by one lane
`define VMUL_WORD_W    32

// Input width of one Dadda multiplier
`define VMUL_ELEM_W    8

// Multipliers per lane, two passes cover a 32x32 product
`define VMUL_NUM_MULT  8

// Packed full-width result, also the accumulator width
`define VMUL_RESULT_W  64

// Product width of one 8x8 multiplier
`define VMUL_PP_W      16

`endif

//--- source/vmul_pkg.sv
`default_nettype none

`include "vmul_defines.svh"

package vmul_pkg;

    // Element width code, 2'b11 is reserved
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10
    } sew_t;

    typedef logic [`VMUL_WORD_W-1:0]                     word_t;
    typedef logic [`VMUL_ELEM_W-1:0]                     elem_t;
    typedef elem_t [`VMUL_NUM_MULT-1:0]                  elem_vec_t;   // One byte per multiplier
    typedef logic [`VMUL_NUM_MULT-1:0][`VMUL_PP_W-1:0]   pp_vec_t;
    typedef logic [`VMUL_RESULT_W-1:0]                   result_t;

    // One flag per byte lane of the operand
    typedef logic [`VMUL_WORD_W/`VMUL_ELEM_W-1:0]        neg_mask_t;

endpackage

`default_nettype wire

//--- source/vmul_control.sv
`default_nettype none

module vmul_control (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  vmul_pkg::word_t a_in,
    input  vmul_pkg::word_t b_in,
    input  vmul_pkg::sew_t  sew_in,
    input  logic            signed_in,
    input  logic            out_ready,
    output logic            out_valid,
    output vmul_pkg::word_t a,
    output vmul_pkg::word_t b,
    output vmul_pkg::sew_t  sew,
    output logic            signed_mode,
    output logic            pass_hi,
    output logic            acc_clear,
    output logic            acc_en
);

    typedef enum logic [1:0] {
        IDLE,
        PASS_LO,   // Low half of B or the only pass for SEW_8/16
        PASS_HI,   // High half of B for SEW_32 only
        DONE
    } state_t;

    state_t state;
    state_t state_next;
    logic   accept;

    assign accept = in_valid && in_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (in_valid) state_next = PASS_LO;
            PASS_LO: state_next = (sew == vmul_pkg::SEW_32) ? PASS_HI : DONE;
            PASS_HI: state_next = DONE;
            DONE:    if (out_ready) state_next = IDLE;   // Hold here under back-pressure
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            sew         <= vmul_pkg::SEW_8;
            signed_mode <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                sew         <= sew_in;
                signed_mode <= signed_in;
            end
        end
    end

    // Operand words stay put until the next request is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            a <= a_in;
            b <= b_in;
        end
    end

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == DONE);
    assign pass_hi   = (state == PASS_HI);
    assign acc_clear = (state == PASS_LO);   // First pass overwrites the accumulator
    assign acc_en    = (state == PASS_LO) || (state == PASS_HI);

    a_no_reserved_sew: assert property (@(posedge clk) disable iff (reset)
        accept |-> sew_in inside {vmul_pkg::SEW_8, vmul_pkg::SEW_16, vmul_pkg::SEW_32});

endmodule

`default_nettype wire

//--- source/operand_prep.sv
`default_nettype none

`include "vmul_defines.svh"

module operand_prep (
    input  vmul_pkg::word_t     a,
    input  vmul_pkg::word_t     b,
    input  vmul_pkg::sew_t      sew,
    input  logic                signed_mode,
    input  logic                pass_hi,
    output vmul_pkg::elem_vec_t mult_a,
    output vmul_pkg::elem_vec_t mult_b,
    output vmul_pkg::neg_mask_t neg_mask
);

    localparam int LANES = `VMUL_WORD_W / `VMUL_ELEM_W;

    vmul_pkg::elem_t [LANES-1:0] a_mag;
    vmul_pkg::elem_t [LANES-1:0] b_mag;
    vmul_pkg::elem_t             b_lo;   // B byte crossed with A bytes at weight 0
    vmul_pkg::elem_t             b_hi;   // B byte crossed with A bytes at weight 8

    // Absolute value of every element at the given width
    function automatic vmul_pkg::word_t magnitude(input vmul_pkg::word_t v,
                                                  input vmul_pkg::sew_t w);
        vmul_pkg::word_t m;
        m = v;
        case (w)
            vmul_pkg::SEW_8: begin
                for (int i = 0; i < 4; i++) begin
                    if (v[8*i+7]) m[8*i +: 8] = ~v[8*i +: 8] + 8'd1;
                end
            end
            vmul_pkg::SEW_16: begin
                for (int i = 0; i < 2; i++) begin
                    if (v[16*i+15]) m[16*i +: 16] = ~v[16*i +: 16] + 16'd1;
                end
            end
            default: if (v[31]) m = ~v + 32'd1;
        endcase
        return m;
    endfunction

    assign a_mag = signed_mode ? magnitude(a, sew) : a;
    assign b_mag = signed_mode ? magnitude(b, sew) : b;

    // Sign flag per byte lane, sign_fixup picks the lanes that lead an element
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            neg_mask[i] = signed_mode & (a[8*i+7] ^ b[8*i+7]);
        end
    end

    assign b_lo = pass_hi ? b_mag[2] : b_mag[0];
    assign b_hi = pass_hi ? b_mag[3] : b_mag[1];

    always_comb begin
        case (sew)
            vmul_pkg::SEW_16: begin   // Four cross products per half-word
                mult_a = {a_mag[3], a_mag[2], a_mag[3], a_mag[2],
                          a_mag[1], a_mag[0], a_mag[1], a_mag[0]};
                mult_b = {b_mag[3], b_mag[3], b_mag[2], b_mag[2],
                          b_mag[1], b_mag[1], b_mag[0], b_mag[0]};
            end
            vmul_pkg::SEW_32: begin
                mult_a = {a_mag, a_mag};
                mult_b = {b_hi, b_hi, b_hi, b_hi, b_lo, b_lo, b_lo, b_lo};
            end
            default: begin   // Byte lanes pair up, upper four multipliers unused
                mult_a = {a_mag, a_mag};
                mult_b = {b_mag, b_mag};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/dadda_8x8.sv
`default_nettype none

`include "vmul_defines.svh"

module dadda_8x8 (
    input  vmul_pkg::elem_t       a,
    input  vmul_pkg::elem_t       b,
    output logic [`VMUL_PP_W-1:0] p
);

    localparam int N_COL = `VMUL_PP_W;
    localparam int MAX_H = `VMUL_ELEM_W;
    localparam int N_STAGE = 4;
    localparam int STAGE_H [N_STAGE] = '{6, 4, 3, 2};   // Dadda heights below 8

    logic [MAX_H-1:0] col [N_COL];   // Bits waiting in each weight column
    logic [MAX_H-1:0] nxt [N_COL];
    int               h   [N_COL];
    int               nh  [N_COL];
    int               k;             // Bits of the column already consumed
    logic             x;
    logic             y;
    logic             z;
    logic             cy;

    always_comb begin
        for (int i = 0; i < N_COL; i++) begin
            col[i] = '0;
            h[i]   = 0;
        end
        for (int r = 0; r < MAX_H; r++) begin
            for (int c = 0; c < MAX_H; c++) begin
                col[r + c][h[r + c]] = a[c] & b[r];
                h[r + c] = h[r + c] + 1;
            end
        end
        for (int s = 0; s < N_STAGE; s++) begin
            for (int i = 0; i < N_COL; i++) begin
                nxt[i] = '0;
                nh[i]  = 0;
            end
            for (int i = 0; i < N_COL; i++) begin
                k = 0;
                // Carries from column i-1 already sit in nh[i]
                for (int n = 0; n < 4; n++) begin
                    x = col[i][k];
                    y = col[i][k + 1];
                    z = col[i][k + 2];
                    if (h[i] - k + nh[i] - STAGE_H[s] >= 2 && h[i] - k >= 3) begin
                        nxt[i][nh[i]] = x ^ y ^ z;   // Full adder
                        cy = (x & y) | (x & z) | (y & z);
                        k = k + 3;
                    end else if (h[i] - k + nh[i] - STAGE_H[s] >= 1 && h[i] - k >= 2) begin
                        nxt[i][nh[i]] = x ^ y;   // Half adder
                        cy = x & y;
                        k = k + 2;
                    end else begin
                        continue;
                    end
                    nh[i] = nh[i] + 1;
                    if (i + 1 < N_COL) begin
                        nxt[i + 1][nh[i + 1]] = cy;
                        nh[i + 1] = nh[i + 1] + 1;
                    end
                end
                for (int j = 0; j < MAX_H; j++) begin
                    if (j >= k && j < h[i]) begin
                        nxt[i][nh[i]] = col[i][j];
                        nh[i] = nh[i] + 1;
                    end
                end
            end
            col = nxt;
            h   = nh;
        end
        // Final ripple adder over the last two rows
        cy = 1'b0;
        for (int i = 0; i < N_COL; i++) begin
            p[i] = col[i][0] ^ col[i][1] ^ cy;
            cy   = (col[i][0] & col[i][1]) | (col[i][0] & cy) | (col[i][1] & cy);
        end
    end

endmodule

`default_nettype wire

//--- source/product_combine.sv
`default_nettype none

`include "vmul_defines.svh"

module product_combine (
    input  logic              clk,
    input  logic              reset,
    input  vmul_pkg::pp_vec_t pp,
    input  vmul_pkg::sew_t    sew,
    input  logic              pass_hi,
    input  logic              acc_clear,
    input  logic              acc_en,
    output vmul_pkg::result_t acc
);

    localparam int HALF_W = `VMUL_WORD_W;
    localparam int PASS_W = `VMUL_WORD_W + `VMUL_PP_W;   // 32x16 partial of one pass

    logic [HALF_W-1:0] half_lo;
    logic [HALF_W-1:0] half_hi;
    logic [PASS_W-1:0] pass_sum;
    vmul_pkg::result_t pass_shifted;
    vmul_pkg::result_t acc_base;
    vmul_pkg::result_t acc_next;

    // SEW_16, each half-word product from its four cross products
    assign half_lo = HALF_W'(pp[0]) + {8'd0, pp[1], 8'd0} + {8'd0, pp[2], 8'd0}
                   + {pp[3], 16'd0};
    assign half_hi = HALF_W'(pp[4]) + {8'd0, pp[5], 8'd0} + {8'd0, pp[6], 8'd0}
                   + {pp[7], 16'd0};

    // SEW_32, A times one B half-word
    always_comb begin
        pass_sum = '0;
        for (int i = 0; i < 4; i++) begin
            pass_sum = pass_sum + (PASS_W'(pp[i]) << (8 * i))
                     + (PASS_W'(pp[i + 4]) << (8 * i + 8));
        end
    end

    assign pass_shifted = pass_hi ? {pass_sum, 16'd0} : {16'd0, pass_sum};
    assign acc_base     = acc_clear ? '0 : acc;

    always_comb begin
        case (sew)
            vmul_pkg::SEW_8:  acc_next = {pp[3], pp[2], pp[1], pp[0]};
            vmul_pkg::SEW_16: acc_next = {half_hi, half_lo};
            default:          acc_next = acc_base + pass_shifted;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc_next;   // Frozen between passes and while the result waits
        end
    end

    // A second pass only exists for a 32-bit element
    a_pass_hi_sew32: assert property (@(posedge clk) disable iff (reset)
        acc_en && pass_hi |-> sew == vmul_pkg::SEW_32);

endmodule

`default_nettype wire

//--- source/sign_fixup.sv
`default_nettype none

module sign_fixup (
    input  vmul_pkg::result_t   acc,
    input  vmul_pkg::sew_t      sew,
    input  vmul_pkg::neg_mask_t neg_mask,
    output vmul_pkg::result_t   result
);

    // Magnitude products turned back into signed results per element
    always_comb begin
        result = acc;
        case (sew)
            vmul_pkg::SEW_8: begin
                for (int i = 0; i < 4; i++) begin
                    if (neg_mask[i]) begin
                        result[16*i +: 16] = ~acc[16*i +: 16] + 16'd1;
                    end
                end
            end
            vmul_pkg::SEW_16: begin
                for (int i = 0; i < 2; i++) begin
                    if (neg_mask[2*i+1]) begin   // Sign sits in the upper byte lane
                        result[32*i +: 32] = ~acc[32*i +: 32] + 32'd1;
                    end
                end
            end
            default: begin
                if (neg_mask[3]) result = ~acc + 64'd1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/vmul_top.sv
`default_nettype none

`include "vmul_defines.svh"

module vmul_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  vmul_pkg::word_t   a,
    input  vmul_pkg::word_t   b,
    input  vmul_pkg::sew_t    sew,
    input  logic              signed_mode,
    output logic              out_valid,
    input  logic              out_ready,
    output vmul_pkg::result_t result
);

    vmul_pkg::word_t     lat_a;
    vmul_pkg::word_t     lat_b;
    vmul_pkg::sew_t      lat_sew;
    logic                lat_signed;
    logic                pass_hi;
    logic                acc_clear;
    logic                acc_en;
    vmul_pkg::elem_vec_t mult_a;
    vmul_pkg::elem_vec_t mult_b;
    vmul_pkg::neg_mask_t neg_mask;
    vmul_pkg::pp_vec_t   pp;
    vmul_pkg::result_t   acc;

    vmul_control i_control (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready),
        .a_in(a), .b_in(b), .sew_in(sew), .signed_in(signed_mode),
        .out_ready(out_ready), .out_valid(out_valid),
        .a(lat_a), .b(lat_b), .sew(lat_sew), .signed_mode(lat_signed),
        .pass_hi(pass_hi), .acc_clear(acc_clear), .acc_en(acc_en)
    );

    operand_prep i_operand_prep (
        .a(lat_a), .b(lat_b), .sew(lat_sew), .signed_mode(lat_signed),
        .pass_hi(pass_hi),
        .mult_a(mult_a), .mult_b(mult_b), .neg_mask(neg_mask)
    );

    for (genvar i = 0; i < `VMUL_NUM_MULT; i++) begin : gen_mult
        dadda_8x8 i_dadda (.a(mult_a[i]), .b(mult_b[i]), .p(pp[i]));
    end

    product_combine i_product_combine (
        .clk(clk), .reset(reset), .pp(pp), .sew(lat_sew), .pass_hi(pass_hi),
        .acc_clear(acc_clear), .acc_en(acc_en), .acc(acc)
    );

    sign_fixup i_sign_fixup (
        .acc(acc), .sew(lat_sew), .neg_mask(neg_mask), .result(result)
    );

endmodule

`default_nettype wire

//--- bench/vmul_checks.svh
`ifndef VMUL_CHECKS_SVH
`define VMUL_CHECKS_SVH

    // Full-precision product of every element pair, packed at twice the element width
    function automatic vmul_pkg::result_t model_product(input vmul_pkg::word_t op_a,
            input vmul_pkg::word_t op_b, input vmul_pkg::sew_t op_sew, input logic op_signed);
        int                w;
        logic [63:0]       ea;
        logic [63:0]       eb;
        logic [63:0]       prod;
        vmul_pkg::result_t r;
        w = (op_sew == vmul_pkg::SEW_8) ? 8 : (op_sew == vmul_pkg::SEW_16) ? 16 : 32;
        r = '0;
        for (int e = 0; e < 32 / w; e++) begin
            for (int j = 0; j < 64; j++) begin
                if (j < w) begin
                    ea[j] = op_a[w * e + j];
                    eb[j] = op_b[w * e + j];
                end else begin   // Sign or zero extension
                    ea[j] = op_signed & op_a[w * e + w - 1];
                    eb[j] = op_signed & op_b[w * e + w - 1];
                end
            end
            prod = ea * eb;   // Low 2w bits hold the exact product
            for (int j = 0; j < 2 * w; j++) begin
                r[2 * w * e + j] = prod[j];
            end
        end
        return r;
    endfunction

    task automatic check_result(input string what, input vmul_pkg::result_t expected,
                                input vmul_pkg::result_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s %s: expected %b, actual %b", cur_test, what, expected, actual);
        end
    endtask

    // Clock edges from acceptance to out_valid
    task automatic check_edges(input string what, input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("ERROR %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
        end
    endtask

`endif

//--- bench/vmul_tb.sv
`default_nettype none

`include "vmul_defines.svh"

module vmul_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_RAND       = 32;   // Random requests per element width
    localparam int N_FIXED      = 32;   // Extreme operand crosses for SEW_8 and SEW_32
    localparam int N_BP         = 24;
    localparam int N_MIXED      = 48;
    localparam int MAX_STALL    = 8;
    localparam int OP_CYCLES    = 6;    // Drive, accept, two passes, handshake and spare
    localparam int N_OPS        = 3 * N_RAND + 2 * N_FIXED + N_BP + N_MIXED;
    localparam int TIMEOUT_NS   = (N_OPS * (OP_CYCLES + MAX_STALL) + RESET_CYCLES) * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    vmul_pkg::word_t   a;
    vmul_pkg::word_t   b;
    vmul_pkg::sew_t    sew;
    logic              signed_mode;
    logic              out_valid;
    logic              out_ready;
    vmul_pkg::result_t result;

    logic [31:0] lcg_state = 32'd81;
    string       cur_test;
    int          check_count = 0;
    int          error_count = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    `include "vmul_checks.svh"

    vmul_top i_vmul_top (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready),
        .a(a), .b(b), .sew(sew), .signed_mode(signed_mode),
        .out_valid(out_valid), .out_ready(out_ready), .result(result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Two LCG steps keep only the upper halves
    function automatic vmul_pkg::word_t next_random();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi, lcg_state[31:16]};
    endfunction

    // Forces some bytes to 0x80 or 0xFF
    function automatic vmul_pkg::word_t add_extremes(input vmul_pkg::word_t w);
        vmul_pkg::word_t r;
        vmul_pkg::word_t pick;
        r = w;
        pick = next_random();
        for (int i = 0; i < 4; i++) begin
            if (pick[4*i +: 2] == 2'd0) r[8*i +: 8] = 8'h80;
            else if (pick[4*i +: 2] == 2'd1) r[8*i +: 8] = 8'hFF;
        end
        return r;
    endfunction

    function automatic vmul_pkg::word_t byte_pattern(input int k);
        case (k)
            0:       return 32'h80808080;
            1:       return 32'hFFFFFFFF;
            2:       return 32'h80FF7F00;
            default: return 32'h7F0180FF;
        endcase
    endfunction

    function automatic vmul_pkg::word_t extreme_word(input int k);
        case (k)
            0:       return 32'h80000000;
            1:       return 32'hFFFFFFFF;
            2:       return 32'h00000000;
            default: return 32'h7FFFFFFF;
        endcase
    endfunction

    function automatic vmul_pkg::sew_t pick_sew(input int k);
        case (k)
            0:       return vmul_pkg::SEW_8;
            1:       return vmul_pkg::SEW_16;
            default: return vmul_pkg::SEW_32;
        endcase
    endfunction

    task automatic start_test(input string name);
        cur_test = name;
        test_start_errors = error_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count != test_start_errors) begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", cur_test, error_count - test_start_errors);
        end else begin
            $display("PASS %s", cur_test);
        end
    endtask

    // Runs one request through both handshakes between two rising edges
    task automatic run_op(input vmul_pkg::word_t op_a, input vmul_pkg::word_t op_b,
                          input vmul_pkg::sew_t op_sew, input logic op_signed, input int stall);
        vmul_pkg::result_t expected;
        int                edges;
        expected = model_product(op_a, op_b, op_sew, op_signed);
        in_valid    <= 1'b1;
        a           <= op_a;
        b           <= op_b;
        sew         <= op_sew;
        signed_mode <= op_signed;
        out_ready   <= (stall == 0);
        @(negedge clk);
        while (!in_ready) begin
            @(posedge clk);
            @(negedge clk);
        end
        @(posedge clk);   // Accepting edge
        in_valid <= 1'b0;
        edges = 1;
        @(negedge clk);
        while (!out_valid) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        check_edges("latency", (op_sew == vmul_pkg::SEW_32) ? 3 : 2, edges);
        check_result("result", expected, result);
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            if (i == stall - 1) out_ready <= 1'b1;
            @(negedge clk);
            check_flag("out_valid under stall", 1'b1, out_valid);
            check_flag("in_ready under stall", 1'b0, in_ready);
            check_result("result under stall", expected, result);
        end
        @(posedge clk);   // Output handshake
        if (stall > 0) begin
            @(negedge clk);
            check_flag("out_valid after handshake", 1'b0, out_valid);
            check_flag("in_ready after handshake", 1'b1, in_ready);
            @(posedge clk);
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("in_ready", 1'b1, in_ready);
        check_result("result", '0, result);
        @(posedge clk);
        finish_test();
    endtask

    task automatic test_width(input string name, input vmul_pkg::sew_t op_sew, input int n_fixed);
        vmul_pkg::word_t op_a;
        vmul_pkg::word_t op_b;
        start_test(name);
        for (int i = 0; i < N_RAND; i++) begin
            op_a = next_random();
            op_b = next_random();
            if (op_sew == vmul_pkg::SEW_8) begin
                op_a = add_extremes(op_a);
                op_b = add_extremes(op_b);
            end
            run_op(op_a, op_b, op_sew, i % 2 == 1, 0);
        end
        for (int k = 0; k < n_fixed; k++) begin   // Every pair of patterns in both modes
            if (op_sew == vmul_pkg::SEW_8) begin
                op_a = byte_pattern(k % 4);
                op_b = byte_pattern((k / 4) % 4);
            end else begin
                op_a = extreme_word(k % 4);
                op_b = extreme_word((k / 4) % 4);
            end
            run_op(op_a, op_b, op_sew, k >= 16, 0);
        end
        finish_test();
    endtask

    task automatic test_random_mix(input string name, input int n_ops, input logic stalled);
        vmul_pkg::word_t op_a;
        vmul_pkg::word_t op_b;
        vmul_pkg::word_t pick;
        int              stall;
        start_test(name);
        for (int i = 0; i < n_ops; i++) begin
            op_a = next_random();
            op_b = next_random();
            pick = next_random();
            stall = stalled ? 1 + int'(pick[15:8]) % MAX_STALL : 0;
            run_op(op_a, op_b, pick_sew(int'(pick[31:16]) % 3), pick[0], stall);
        end
        finish_test();
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        a           = '0;
        b           = '0;
        sew         = vmul_pkg::SEW_8;
        signed_mode = 1'b0;
        out_ready   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_width("sew8_random", vmul_pkg::SEW_8, N_FIXED);
        test_width("sew16_random", vmul_pkg::SEW_16, 0);
        test_width("sew32_random", vmul_pkg::SEW_32, N_FIXED);
        test_random_mix("back_pressure", N_BP, 1'b1);
        test_random_mix("mixed_back_to_back", N_MIXED, 1'b0);
        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog sized for every operation at its worst stall
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT stopped responding before all requests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
+incdir+bench
source/vmul_pkg.sv
source/vmul_control.sv
source/operand_prep.sv
source/dadda_8x8.sv
source/product_combine.sv
source/sign_fixup.sv
source/vmul_top.sv
bench/vmul_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vmul lane testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vmul_tb -f project.f -o vmul_sim
./obj_dir/vmul_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1
